//--- logic/lvds_rx_params.svh
`ifndef LVDS_RX_PARAMS_SVH
`define LVDS_RX_PARAMS_SVH

// Number of serial receive lanes in the bank
`define LVDS_LANES 4

// Tap value width and number of delay stages behind it
`define LVDS_TAP_W 5
`define LVDS_TAP_DEPTH 32

// Byte address of the control register
`define LVDS_CSR_ADDR 32'h0000_0100

`endif

//--- logic/lvds_rx_pkg.sv
`default_nettype none

`include "lvds_rx_params.svh"

package lvds_rx_pkg;

    // --------------------
    // Register bus
    // --------------------

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        valid;
    } mem_fwd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } mem_ret_t;

    // --------------------
    // Lane data widths
    // --------------------

    typedef logic [7:0]             lane_sel_t;
    typedef logic [`LVDS_TAP_W-1:0] tap_t;
    typedef logic [7:0]             rx_byte_t;

    // Control register field positions
    localparam int SEL_LSB   = 0;
    localparam int TAP_LSB   = 8;
    localparam int RESET_BIT = 16;
    localparam int SLIP_BIT  = 17;

endpackage

`default_nettype wire

//--- logic/csr_block.sv
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module csr_block import lvds_rx_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire mem_fwd_t  bus_fwd,
    output mem_ret_t       bus_ret,
    input  wire [31:0]     readback,
    output lane_sel_t      lane_sel,
    output tap_t           tap_val,
    output logic           tap_wr,
    output logic           lane_reset_req,
    output logic           slip_req
);

    logic        ready_q;
    logic [31:0] rdata_q;
    logic        accept;
    logic        is_wr;

    // Take the access once, the cycle after valid rises
    assign accept = bus_fwd.valid && (bus_fwd.addr == `LVDS_CSR_ADDR) && !ready_q;
    assign is_wr  = |bus_fwd.wstrb;

    // --------------------
    // Stored fields and strobes
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q        <= 1'b0;
            lane_sel       <= '0;
            tap_val        <= '0;
            tap_wr         <= 1'b0;
            lane_reset_req <= 1'b0;
            slip_req       <= 1'b0;
        end else begin
            ready_q        <= accept;
            tap_wr         <= accept && bus_fwd.wstrb[TAP_LSB/8];
            lane_reset_req <= accept && bus_fwd.wstrb[RESET_BIT/8] &&
                              bus_fwd.wdata[RESET_BIT];
            slip_req       <= accept && bus_fwd.wstrb[SLIP_BIT/8] &&
                              bus_fwd.wdata[SLIP_BIT];
            if (accept && bus_fwd.wstrb[SEL_LSB/8]) begin
                lane_sel <= bus_fwd.wdata[SEL_LSB +: 8];
            end
            if (accept && bus_fwd.wstrb[TAP_LSB/8]) begin
                tap_val <= bus_fwd.wdata[TAP_LSB +: `LVDS_TAP_W];
            end
        end
    end

    // Read data is presented together with ready
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= is_wr ? 32'h0 : readback;
        end
    end

    always_comb begin
        bus_ret.rdata = rdata_q;
        bus_ret.ready = ready_q;
    end

    // Ready is a single-cycle pulse per access
    ready_pulse_a: assert property (
        @(posedge clk) disable iff (reset)
        bus_ret.ready |=> !bus_ret.ready
    );

endmodule

`default_nettype wire

//--- logic/tap_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module tap_delay_line import lvds_rx_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic din,
    input  wire logic tap_ld,
    input  wire tap_t tap_in,
    output tap_t      tap,
    output logic      dout
);

    // Older bits live in the history, the newest is din itself
    logic [`LVDS_TAP_DEPTH-2:0] hist;
    logic [`LVDS_TAP_DEPTH-1:0] window;

    assign window = {hist, din};

    always_ff @(posedge clk) begin
        if (reset) begin
            tap  <= '0;
            hist <= '0;
            dout <= 1'b0;
        end else begin
            if (tap_ld) begin
                tap <= tap_in;
            end
            hist <= {hist[`LVDS_TAP_DEPTH-3:0], din};
            // Output lags the input by tap + 1 cycles
            dout <= window[tap];
        end
    end

    // Tap only moves after a load strobe
    tap_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (tap != $past(tap)) |-> $past(tap_ld)
    );

endmodule

`default_nettype wire

//--- logic/lane_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

module lane_deserializer import lvds_rx_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic din,
    input  wire logic lane_reset,
    input  wire logic slip,
    output rx_byte_t  dout,
    output logic      dout_valid
);

    logic [6:0] sr;
    logic [2:0] cnt;
    logic       capture;

    // A slip at the frame end postpones the capture with the counter
    assign capture = (cnt == 3'd7) && !slip;

    // --------------------
    // Shift and framing
    // --------------------

    always_ff @(posedge clk) begin
        if (reset || lane_reset) begin
            sr  <= '0;
            cnt <= '0;
        end else begin
            // Newest bit enters at bit 0
            sr <= {sr[5:0], din};
            if (!slip) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // --------------------
    // Byte capture
    // --------------------

    always_ff @(posedge clk) begin
        if (reset || lane_reset) begin
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= capture;
            if (capture) begin
                // Oldest bit of the frame lands in bit 7
                dout <= {sr, din};
            end
        end
    end

    // At most one byte per frame
    valid_gap_a: assert property (
        @(posedge clk) disable iff (reset)
        dout_valid |=> !dout_valid
    );

endmodule

`default_nettype wire

//--- logic/lvds_rx_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_bank import lvds_rx_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire [`LVDS_LANES-1:0]        serial_in,
    input  wire mem_fwd_t                bus_fwd,
    output mem_ret_t                     bus_ret,
    output logic [8*`LVDS_LANES-1:0]     dout,
    output logic [`LVDS_LANES-1:0]       dout_valid,
    output logic [8*`LVDS_LANES-1:0]     bitwise_out
);

    localparam int LANES   = `LVDS_LANES;
    localparam int IDX_W   = $clog2(LANES);
    localparam int MON_LSB = 16;

    logic [31:0]      readback;
    lane_sel_t        lane_sel;
    tap_t             tap_val;
    logic             tap_wr;
    logic             lane_reset_req;
    logic             slip_req;

    logic [LANES-1:0] tap_ld_vec;
    logic [LANES-1:0] reset_vec;
    logic [LANES-1:0] slip_vec;

    tap_t             tap_arr  [LANES];
    rx_byte_t         lane_byte[LANES];
    rx_byte_t         mon      [LANES];
    logic [LANES-1:0] delayed;

    logic             sel_ok;
    tap_t             tap_mux;
    rx_byte_t         mon_mux;

    csr_block u_csr (
        .clk            (clk),
        .reset          (reset),
        .bus_fwd        (bus_fwd),
        .bus_ret        (bus_ret),
        .readback       (readback),
        .lane_sel       (lane_sel),
        .tap_val        (tap_val),
        .tap_wr         (tap_wr),
        .lane_reset_req (lane_reset_req),
        .slip_req       (slip_req)
    );

    // --------------------
    // Lane strobe decoders
    // --------------------

    // A select past the last lane shifts the strobe out entirely
    assign tap_ld_vec = {{(LANES-1){1'b0}}, tap_wr} << lane_sel;
    assign reset_vec  = {{(LANES-1){1'b0}}, lane_reset_req} << lane_sel;
    assign slip_vec   = {{(LANES-1){1'b0}}, slip_req} << lane_sel;

    // --------------------
    // Readback
    // --------------------

    assign sel_ok  = lane_sel < lane_sel_t'(LANES);
    assign tap_mux = sel_ok ? tap_arr[lane_sel[IDX_W-1:0]] : '0;
    assign mon_mux = sel_ok ? mon[lane_sel[IDX_W-1:0]] : '0;

    always_comb begin
        readback                        = '0;
        readback[SEL_LSB +: 8]          = lane_sel;
        readback[TAP_LSB +: `LVDS_TAP_W] = tap_mux;
        readback[MON_LSB +: 8]          = mon_mux;
    end

    // --------------------
    // Lanes
    // --------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        tap_delay_line u_tap (
            .clk    (clk),
            .reset  (reset),
            .din    (serial_in[i]),
            .tap_ld (tap_ld_vec[i]),
            .tap_in (tap_val),
            .tap    (tap_arr[i]),
            .dout   (delayed[i])
        );

        lane_deserializer u_des (
            .clk        (clk),
            .reset      (reset),
            .din        (delayed[i]),
            .lane_reset (reset_vec[i]),
            .slip       (slip_vec[i]),
            .dout       (lane_byte[i]),
            .dout_valid (dout_valid[i])
        );

        assign dout[8*i +: 8] = lane_byte[i];

        // Latest byte of the lane for link training
        always_ff @(posedge clk) begin
            if (reset) begin
                mon[i] <= '0;
            end else if (dout_valid[i]) begin
                mon[i] <= lane_byte[i];
            end
        end

        // Bit-major order, bit j of every lane side by side
        for (genvar j = 0; j < 8; j++) begin : g_remap
            assign bitwise_out[LANES*j + i] = lane_byte[i][j];
        end
    end

endmodule

`default_nettype wire

//--- verif/lvds_rx_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_bank_tb import lvds_rx_pkg::*; ();

    localparam int LANES     = `LVDS_LANES;
    localparam int MAX_CYCLE = 4000;

    logic                   clk;
    logic                   reset;
    logic [LANES-1:0]       serial_in;
    mem_fwd_t               bus_fwd;
    mem_ret_t               bus_ret;
    logic [8*LANES-1:0]     dout;
    logic [LANES-1:0]       dout_valid;
    logic [8*LANES-1:0]     bitwise_out;

    rx_byte_t   pat       [LANES];
    tap_t       tap_model [LANES];
    rx_byte_t   last_byte [LANES];
    rx_byte_t   last_q    [LANES];
    rx_byte_t   slip_ref  [LANES];
    logic [LANES-1:0] slip_armed;
    logic [LANES-1:0] rot_en;
    logic [LANES-1:0] stab_en;
    logic [2:0] phase;
    logic [31:0] rng;
    lane_sel_t  cur_sel;
    int         slip_lane;
    int         rst_lane;
    logic       slip_pending;
    logic       rst_pending;
    logic       rst_armed;
    logic       rd_chk;
    logic       noack_chk;
    logic       idle_chk;
    int         errors;
    int         tests;
    int         cycles;

    lvds_rx_bank u_dut (
        .clk         (clk),
        .reset       (reset),
        .serial_in   (serial_in),
        .bus_fwd     (bus_fwd),
        .bus_ret     (bus_ret),
        .dout        (dout),
        .dout_valid  (dout_valid),
        .bitwise_out (bitwise_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rx_byte_t rotl(input rx_byte_t b, input int n);
        rx_byte_t r;
        r = b;
        for (int k = 0; k < n; k++) begin
            r = {r[6:0], r[7]};
        end
        return r;
    endfunction

    function automatic logic is_rotation(input rx_byte_t b, input rx_byte_t p);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 8; k++) begin
            if (rotl(p, k) == b) hit = 1'b1;
        end
        return hit;
    endfunction

    // Bit j of lane i goes to position LANES*j + i
    function automatic logic [8*LANES-1:0] bit_major(input logic [8*LANES-1:0] d);
        logic [8*LANES-1:0] r;
        r = '0;
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < 8; j++) begin
                r[LANES*j + i] = d[8*i + j];
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] expected_readback(input lane_sel_t s);
        logic [31:0] r;
        r = '0;
        r[7:0] = s;
        if (s < lane_sel_t'(LANES)) begin
            r[12:8]  = tap_model[s[1:0]];
            r[23:16] = last_q[s[1:0]];
        end
        return r;
    endfunction

    // --------------------
    // Stimulus and bus tasks
    // --------------------

    // Each lane repeats its pattern with the oldest bit (bit 7) first
    always @(posedge clk) begin
        #1;
        phase <= phase + 3'd1;
        for (int i = 0; i < LANES; i++) begin
            serial_in[i] <= pat[i][3'd7 - phase];
        end
    end

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        bus_fwd = '{addr: addr, wdata: data, wstrb: strb, valid: 1'b1};
        do begin
            @(posedge clk);
            #1;
        end while (!bus_ret.ready);
        bus_fwd.valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] data, input logic [3:0] strb);
        if (strb[0]) cur_sel = data[7:0];
        if (strb[1] && cur_sel < lane_sel_t'(LANES)) begin
            tap_model[cur_sel[1:0]] = data[12:8];
        end
        bus_access(`LVDS_CSR_ADDR, data, strb);
    endtask

    task automatic bus_read();
        rd_chk = 1'b1;
        bus_access(`LVDS_CSR_ADDR, 32'h0, 4'h0);
        rd_chk = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    // Reference state that follows the lane outputs
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LANES; i++) begin
                last_byte[i] <= '0;
                last_q[i]    <= '0;
            end
            slip_armed <= '0;
            rst_armed  <= 1'b0;
        end else begin
            rst_armed <= bus_ret.ready && rst_pending;
            for (int i = 0; i < LANES; i++) begin
                last_q[i] <= last_byte[i];
                if (dout_valid[i]) last_byte[i] <= dout[8*i +: 8];
                if (bus_ret.ready && slip_pending && slip_lane == i) begin
                    slip_armed[i] <= 1'b1;
                    slip_ref[i]   <= dout_valid[i] ? dout[8*i +: 8] : last_byte[i];
                end else if (dout_valid[i]) begin
                    slip_armed[i] <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // Checks
    // --------------------

    idle_a: assert property (@(posedge clk) disable iff (reset)
        idle_chk |-> (dout_valid == '0 && !bus_ret.ready && dout == '0))
        else begin
            errors++;
            $display("[FAIL] idle outputs: dout_valid %h ready %h dout %h",
                     dout_valid, bus_ret.ready, dout);
        end

    readback_a: assert property (@(posedge clk) disable iff (reset)
        (rd_chk && bus_ret.ready) |-> bus_ret.rdata == expected_readback(cur_sel))
        else begin
            errors++;
            $display("[FAIL] bus_ret.rdata: got %h expected %h",
                     bus_ret.rdata, expected_readback(cur_sel));
        end

    noack_a: assert property (@(posedge clk) disable iff (reset)
        noack_chk |-> !bus_ret.ready)
        else begin
            errors++;
            $display("Ready answered an access to an unmapped address");
        end

    remap_a: assert property (@(posedge clk) bitwise_out == bit_major(dout))
        else begin
            errors++;
            $display("[FAIL] bitwise_out: got %h expected %h", bitwise_out, bit_major(dout));
        end

    lane_reset_a: assert property (@(posedge clk) disable iff (reset)
        rst_armed |-> dout[8*rst_lane +: 8] == 8'h00)
        else begin
            errors++;
            $display("[FAIL] dout lane %0d after reset: got %h expected 00",
                     rst_lane, dout[8*rst_lane +: 8]);
        end

    for (genvar i = 0; i < LANES; i++) begin : g_chk
        rotation_a: assert property (@(posedge clk) disable iff (reset)
            (dout_valid[i] && rot_en[i]) |-> is_rotation(dout[8*i +: 8], pat[i]))
            else begin
                errors++;
                $display("[FAIL] dout lane %0d: got %h, no rotation of %h",
                         i, dout[8*i +: 8], pat[i]);
            end

        stable_a: assert property (@(posedge clk) disable iff (reset)
            (dout_valid[i] && stab_en[i] && !slip_armed[i]) |->
            dout[8*i +: 8] == last_byte[i])
            else begin
                errors++;
                $display("[FAIL] dout lane %0d: got %h expected %h",
                         i, dout[8*i +: 8], last_byte[i]);
            end

        slip_a: assert property (@(posedge clk) disable iff (reset)
            (dout_valid[i] && slip_armed[i]) |-> dout[8*i +: 8] == rotl(slip_ref[i], 1))
            else begin
                errors++;
                $display("[FAIL] dout lane %0d after slip: got %h expected %h",
                         i, dout[8*i +: 8], rotl(slip_ref[i], 1));
            end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLE) begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        reset        = 1'b1;
        serial_in    = '0;
        bus_fwd      = '0;
        phase        = '0;
        cur_sel      = '0;
        slip_lane    = 0;
        rst_lane     = 0;
        slip_pending = 1'b0;
        rst_pending  = 1'b0;
        rd_chk       = 1'b0;
        noack_chk    = 1'b0;
        idle_chk     = 1'b0;
        rot_en       = '0;
        stab_en      = '0;
        errors       = 0;
        tests        = 0;
        cycles       = 0;
        rng          = 32'h27af;
        for (int i = 0; i < LANES; i++) begin
            tap_model[i] = '0;
            // Skip patterns that repeat under rotation
            do begin
                rng    = xorshift(rng);
                pat[i] = rng[7:0];
            end while (rotl(pat[i], 1) == pat[i] || rotl(pat[i], 2) == pat[i] ||
                       rotl(pat[i], 4) == pat[i]);
        end
        repeat (16) @(posedge clk);
        #1;
        reset    = 1'b0;
        idle_chk = 1'b1;
        wait_cycles(3);
        idle_chk = 1'b0;
        bus_read();
        finish_test("reset state");

        bus_write(32'h0000_0302, 4'h3);
        bus_read();
        noack_chk = 1'b1;
        bus_fwd   = '{addr: `LVDS_CSR_ADDR + 32'h4, wdata: 32'h1, wstrb: 4'h1, valid: 1'b1};
        wait_cycles(5);
        bus_fwd.valid = 1'b0;
        wait_cycles(2);
        noack_chk = 1'b0;
        bus_read();
        finish_test("register write and read");

        bus_write(32'h0000_0502, 4'h3);
        for (int i = 0; i <= LANES; i++) begin
            bus_write(i, 4'h1);
            bus_read();
        end
        finish_test("tap readback");

        // Let every delay line settle before the byte checks
        wait_cycles(40);
        rot_en  = '1;
        stab_en = '1;
        wait_cycles(40);
        for (int i = 0; i < LANES; i++) begin
            bus_write(i, 4'h1);
            bus_read();
        end
        finish_test("byte framing");

        for (int k = 0; k < 3; k++) begin
            slip_lane = (k == 2) ? 3 : 1 - k;
            bus_write(slip_lane, 4'h1);
            slip_pending = 1'b1;
            bus_write(32'h1 << SLIP_BIT, 4'h4);
            slip_pending = 1'b0;
            while (slip_armed[slip_lane]) @(posedge clk);
            #1;
            wait_cycles(10);
        end
        rst_lane = 3;
        bus_write(rst_lane, 4'h1);
        stab_en[rst_lane] = 1'b0;
        rst_pending = 1'b1;
        bus_write(32'h1 << RESET_BIT, 4'h4);
        rst_pending = 1'b0;
        wait_cycles(20);
        finish_test("bitslip and lane reset");

        wait_cycles(8);
        finish_test("bit-major remap");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/lvds_rx_pkg.sv
logic/csr_block.sv
logic/tap_delay_line.sv
logic/lane_deserializer.sv
logic/lvds_rx_bank.sv
verif/lvds_rx_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lvds_rx_bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module lvds_rx_bank_tb \
    -f all.f \
    -o lvds_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/lvds_rx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
